/* hdl/data_cache_pkg.sv */
package data_cache_pkg;

    parameter int BYTE_WIDTH     = 8;
    parameter int WORD_WIDTH     = 32;
    parameter int WORD_BYTES     = WORD_WIDTH / BYTE_WIDTH;  // also the byte enable width
    parameter int BANK_SEL_WIDTH = 2;
    parameter int ROW_WIDTH      = 8;
    parameter int ADDR_WIDTH     = BANK_SEL_WIDTH + ROW_WIDTH;
    parameter int ROW_COUNT      = 1 << ROW_WIDTH;  // rows held by each bank

    typedef logic [WORD_WIDTH - 1:0] word_t;

    typedef logic [WORD_BYTES - 1:0] byte_en_t;  // bit k writes byte k of the word

    typedef logic [ROW_WIDTH - 1:0] row_t;

    typedef logic [BANK_SEL_WIDTH - 1:0] bank_sel_t;

    // Split view of a word address. The bank index sits above the row so that
    // consecutive rows of one bank are contiguous in the flat address space.
    typedef struct packed {
        bank_sel_t bank;
        row_t      row;
    } cache_addr_fields_t;

    typedef union packed {
        logic [ADDR_WIDTH - 1:0] flat;    // plain word address as seen on the ports
        cache_addr_fields_t      fields;  // bank and row as seen by the decoder
    } cache_addr_u;

endpackage : data_cache_pkg

/* hdl/cache_request_decoder.sv */
module cache_request_decoder #(
    parameter int BANK_COUNT = 4
) (
    input  logic                          p0_wr_valid_i,
    input  data_cache_pkg::cache_addr_u   p0_wr_addr_i,
    input  logic                          p0_rd_valid_i,
    input  data_cache_pkg::cache_addr_u   p0_rd_addr_i,
    input  logic                          p1_rd_valid_i,
    input  data_cache_pkg::cache_addr_u   p1_rd_addr_i,

    output logic [BANK_COUNT - 1:0]       bank_wr_en_o,
    output logic [BANK_COUNT - 1:0]       bank_p0_rd_en_o,
    output logic [BANK_COUNT - 1:0]       bank_p1_rd_en_o,
    output data_cache_pkg::row_t          wr_row_o,
    output data_cache_pkg::row_t          p0_rd_row_o,
    output data_cache_pkg::row_t          p1_rd_row_o,
    output data_cache_pkg::bank_sel_t     p0_rd_bank_o,
    output data_cache_pkg::bank_sel_t     p1_rd_bank_o
);

    // one hot bank enable, all zero when the request is idle or out of range
    function automatic logic [BANK_COUNT - 1:0] bank_enable(
        input logic                      valid,
        input data_cache_pkg::bank_sel_t bank
    );
        logic [BANK_COUNT - 1:0] en;
        en = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            if (valid && (int'(bank) == b)) begin
                en[b] = 1'b1;
            end
        end
        return en;
    endfunction

    always_comb begin
        bank_wr_en_o    = bank_enable(p0_wr_valid_i, p0_wr_addr_i.fields.bank);
        bank_p0_rd_en_o = bank_enable(p0_rd_valid_i, p0_rd_addr_i.fields.bank);
        bank_p1_rd_en_o = bank_enable(p1_rd_valid_i, p1_rd_addr_i.fields.bank);
    end

    // rows go to every bank, only the enabled one acts on them
    assign wr_row_o    = p0_wr_addr_i.fields.row;
    assign p0_rd_row_o = p0_rd_addr_i.fields.row;
    assign p1_rd_row_o = p1_rd_addr_i.fields.row;

    assign p0_rd_bank_o = p0_rd_addr_i.fields.bank;  // collector needs it a cycle later
    assign p1_rd_bank_o = p1_rd_addr_i.fields.bank;

    // a valid request must name a bank that was generated
    always_comb begin
        assert final (!(p0_wr_valid_i === 1'b1 && int'(p0_wr_addr_i.fields.bank) >= BANK_COUNT))
            else $error("port 0 write addresses a bank that is not built");
        assert final (!(p0_rd_valid_i === 1'b1 && int'(p0_rd_addr_i.fields.bank) >= BANK_COUNT))
            else $error("port 0 read addresses a bank that is not built");
        assert final (!(p1_rd_valid_i === 1'b1 && int'(p1_rd_addr_i.fields.bank) >= BANK_COUNT))
            else $error("port 1 read addresses a bank that is not built");
    end

endmodule : cache_request_decoder

/* hdl/data_memory_bank.sv */
module data_memory_bank (
    input  logic                        clk_i,

    // port 0 write side
    input  logic                        wr_en_i,
    input  data_cache_pkg::byte_en_t    byte_en_i,
    input  data_cache_pkg::row_t        wr_row_i,
    input  data_cache_pkg::word_t       wr_data_i,

    // port 0 read side
    input  logic                        p0_rd_en_i,
    input  data_cache_pkg::row_t        p0_rd_row_i,
    output data_cache_pkg::word_t       p0_rd_data_o,

    // port 1, read only
    input  logic                        p1_rd_en_i,
    input  data_cache_pkg::row_t        p1_rd_row_i,
    output data_cache_pkg::word_t       p1_rd_data_o
);

    data_cache_pkg::word_t mem [data_cache_pkg::ROW_COUNT];  // contents are undefined until written

    data_cache_pkg::word_t p0_rd_data_q;
    data_cache_pkg::word_t p1_rd_data_q;

    // byte granular write, untouched bytes keep their old value
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < data_cache_pkg::WORD_BYTES; b++) begin
                if (byte_en_i[b]) begin
                    mem[wr_row_i][b * data_cache_pkg::BYTE_WIDTH +: data_cache_pkg::BYTE_WIDTH]
                        <= wr_data_i[b * data_cache_pkg::BYTE_WIDTH +: data_cache_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    // Both read registers sample the array before the write above lands,
    // which gives read-before-write on a same row collision.
    always_ff @(posedge clk_i) begin
        if (p0_rd_en_i) begin
            p0_rd_data_q <= mem[p0_rd_row_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (p1_rd_en_i) begin
            p1_rd_data_q <= mem[p1_rd_row_i];
        end
    end

    assign p0_rd_data_o = p0_rd_data_q;  // holds the last read when idle
    assign p1_rd_data_o = p1_rd_data_q;

endmodule : data_memory_bank

/* hdl/bank_read_collector.sv */
module bank_read_collector #(
    parameter int BANK_COUNT = 4
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    input  logic                                        p0_rd_valid_i,
    input  data_cache_pkg::bank_sel_t                   p0_rd_bank_i,
    input  logic                                        p1_rd_valid_i,
    input  data_cache_pkg::bank_sel_t                   p1_rd_bank_i,

    input  data_cache_pkg::word_t [BANK_COUNT - 1:0]    bank_p0_data_i,
    input  data_cache_pkg::word_t [BANK_COUNT - 1:0]    bank_p1_data_i,

    output data_cache_pkg::word_t                       p0_rd_data_o,
    output data_cache_pkg::word_t                       p1_rd_data_o,
    output logic                                        p0_rd_valid_o,
    output logic                                        p1_rd_valid_o
);

    logic                      p0_valid_q;
    logic                      p1_valid_q;
    data_cache_pkg::bank_sel_t p0_bank_q;  // bank whose register holds the port 0 result
    data_cache_pkg::bank_sel_t p1_bank_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p0_valid_q <= 1'b0;
            p1_valid_q <= 1'b0;
        end else begin
            p0_valid_q <= p0_rd_valid_i;
            p1_valid_q <= p1_rd_valid_i;
        end
    end

    // bank index of each read, it picks the result one cycle later
    always_ff @(posedge clk_i) begin
        p0_bank_q <= p0_rd_bank_i;
        p1_bank_q <= p1_rd_bank_i;
    end

    assign p0_rd_data_o  = bank_p0_data_i[p0_bank_q];
    assign p1_rd_data_o  = bank_p1_data_i[p1_bank_q];
    assign p0_rd_valid_o = p0_valid_q;
    assign p1_rd_valid_o = p1_valid_q;

    // A valid result must point at a bank that exists. The decoder already
    // filtered the request a cycle earlier, so this checks the hand-over.
    p0_bank_in_range_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p0_rd_valid_o |-> (int'(p0_bank_q) < BANK_COUNT))
        else $error("port 0 result selects a bank that is not built");

    p1_bank_in_range_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p1_rd_valid_o |-> (int'(p1_bank_q) < BANK_COUNT))
        else $error("port 1 result selects a bank that is not built");

endmodule : bank_read_collector

/* hdl/data_cache_block.sv */
module data_cache_block #(
    parameter int BANK_COUNT = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // port 0 write request
    input  logic                        p0_wr_valid_i,
    input  data_cache_pkg::cache_addr_u p0_wr_addr_i,
    input  data_cache_pkg::word_t       p0_wr_data_i,
    input  data_cache_pkg::byte_en_t    p0_byte_en_i,

    // port 0 read request and result
    input  logic                        p0_rd_valid_i,
    input  data_cache_pkg::cache_addr_u p0_rd_addr_i,
    output data_cache_pkg::word_t       p0_rd_data_o,
    output logic                        p0_rd_valid_o,

    // port 1 read request and result
    input  logic                        p1_rd_valid_i,
    input  data_cache_pkg::cache_addr_u p1_rd_addr_i,
    output data_cache_pkg::word_t       p1_rd_data_o,
    output logic                        p1_rd_valid_o
);

    logic [BANK_COUNT - 1:0]                 bank_wr_en;
    logic [BANK_COUNT - 1:0]                 bank_p0_rd_en;
    logic [BANK_COUNT - 1:0]                 bank_p1_rd_en;
    data_cache_pkg::row_t                    wr_row;
    data_cache_pkg::row_t                    p0_rd_row;
    data_cache_pkg::row_t                    p1_rd_row;
    data_cache_pkg::bank_sel_t               rd0_bank_sel;
    data_cache_pkg::bank_sel_t               rd1_bank_sel;
    data_cache_pkg::word_t [BANK_COUNT - 1:0] bank_p0_data;  // one registered word per bank
    data_cache_pkg::word_t [BANK_COUNT - 1:0] bank_p1_data;

    cache_request_decoder #(
        .BANK_COUNT      ( BANK_COUNT    )
    ) i_cache_request_decoder (
        .p0_wr_valid_i   ( p0_wr_valid_i ),
        .p0_wr_addr_i    ( p0_wr_addr_i  ),
        .p0_rd_valid_i   ( p0_rd_valid_i ),
        .p0_rd_addr_i    ( p0_rd_addr_i  ),
        .p1_rd_valid_i   ( p1_rd_valid_i ),
        .p1_rd_addr_i    ( p1_rd_addr_i  ),
        .bank_wr_en_o    ( bank_wr_en    ),
        .bank_p0_rd_en_o ( bank_p0_rd_en ),
        .bank_p1_rd_en_o ( bank_p1_rd_en ),
        .wr_row_o        ( wr_row        ),
        .p0_rd_row_o     ( p0_rd_row     ),
        .p1_rd_row_o     ( p1_rd_row     ),
        .p0_rd_bank_o    ( rd0_bank_sel  ),
        .p1_rd_bank_o    ( rd1_bank_sel  )
    );

    // write data, byte enables and rows are broadcast, the enables pick the bank
    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
        data_memory_bank i_data_memory_bank (
            .clk_i        ( clk_i            ),
            .wr_en_i      ( bank_wr_en[g]    ),
            .byte_en_i    ( p0_byte_en_i     ),
            .wr_row_i     ( wr_row           ),
            .wr_data_i    ( p0_wr_data_i     ),
            .p0_rd_en_i   ( bank_p0_rd_en[g] ),
            .p0_rd_row_i  ( p0_rd_row        ),
            .p0_rd_data_o ( bank_p0_data[g]  ),
            .p1_rd_en_i   ( bank_p1_rd_en[g] ),
            .p1_rd_row_i  ( p1_rd_row        ),
            .p1_rd_data_o ( bank_p1_data[g]  )
        );
    end : g_bank

    bank_read_collector #(
        .BANK_COUNT     ( BANK_COUNT    )
    ) i_bank_read_collector (
        .clk_i          ( clk_i         ),
        .rst_n_i        ( rst_n_i       ),
        .p0_rd_valid_i  ( p0_rd_valid_i ),
        .p0_rd_bank_i   ( rd0_bank_sel  ),
        .p1_rd_valid_i  ( p1_rd_valid_i ),
        .p1_rd_bank_i   ( rd1_bank_sel  ),
        .bank_p0_data_i ( bank_p0_data  ),
        .bank_p1_data_i ( bank_p1_data  ),
        .p0_rd_data_o   ( p0_rd_data_o  ),
        .p1_rd_data_o   ( p1_rd_data_o  ),
        .p0_rd_valid_o  ( p0_rd_valid_o ),
        .p1_rd_valid_o  ( p1_rd_valid_o )
    );

endmodule : data_cache_block

/* verification/data_cache_block_tb.sv */
module data_cache_block_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BANK_COUNT   = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int ADDR_W       = data_cache_pkg::ADDR_WIDTH;
    localparam int ADDR_COUNT   = 1 << ADDR_W;
    localparam int STREAM_LEN   = 64;
    localparam int DIRECTED_OPS = 200;  // cycles of the short directed tests, with margin
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + ADDR_COUNT + STREAM_LEN + DIRECTED_OPS);

    logic                        clk_i;
    logic                        rst_n_i;
    logic                        p0_wr_valid_i;
    data_cache_pkg::cache_addr_u p0_wr_addr_i;
    data_cache_pkg::word_t       p0_wr_data_i;
    data_cache_pkg::byte_en_t    p0_byte_en_i;
    logic                        p0_rd_valid_i;
    data_cache_pkg::cache_addr_u p0_rd_addr_i;
    data_cache_pkg::word_t       p0_rd_data_o;
    logic                        p0_rd_valid_o;
    logic                        p1_rd_valid_i;
    data_cache_pkg::cache_addr_u p1_rd_addr_i;
    data_cache_pkg::word_t       p1_rd_data_o;
    logic                        p1_rd_valid_o;

    data_cache_pkg::word_t model [ADDR_COUNT];  // expected contents by flat address
    data_cache_pkg::word_t exp_p0 [$];
    data_cache_pkg::word_t exp_p1 [$];
    int seed = 1;
    int checks_done = 0;

    data_cache_block #(
        .BANK_COUNT    ( BANK_COUNT    )
    ) i_data_cache_block (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .p0_wr_valid_i ( p0_wr_valid_i ),
        .p0_wr_addr_i  ( p0_wr_addr_i  ),
        .p0_wr_data_i  ( p0_wr_data_i  ),
        .p0_byte_en_i  ( p0_byte_en_i  ),
        .p0_rd_valid_i ( p0_rd_valid_i ),
        .p0_rd_addr_i  ( p0_rd_addr_i  ),
        .p0_rd_data_o  ( p0_rd_data_o  ),
        .p0_rd_valid_o ( p0_rd_valid_o ),
        .p1_rd_valid_i ( p1_rd_valid_i ),
        .p1_rd_addr_i  ( p1_rd_addr_i  ),
        .p1_rd_data_o  ( p1_rd_data_o  ),
        .p1_rd_valid_o ( p1_rd_valid_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input data_cache_pkg::word_t expected,
                              input data_cache_pkg::word_t actual);
        checks_done++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        checks_done++;
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected %b, got %b",
                                     $time, name, expected, actual));
        end
    endtask

    // byte k of the new word lands only where enable bit k is set
    function automatic data_cache_pkg::word_t merge_bytes(input data_cache_pkg::word_t old_word,
                                                          input data_cache_pkg::word_t new_word,
                                                          input data_cache_pkg::byte_en_t be);
        data_cache_pkg::word_t merged;
        merged = old_word;
        for (int k = 0; k < data_cache_pkg::WORD_BYTES; k++) begin
            if (be[k]) begin
                merged[8 * k +: 8] = new_word[8 * k +: 8];
            end
        end
        return merged;
    endfunction

    function automatic data_cache_pkg::word_t fill_word(input logic [ADDR_W - 1:0] addr);
        return {6'h2a, addr, 6'h15, ~addr};  // every address bit shows up twice
    endfunction

    task automatic check_idle();
        @(negedge clk_i);
        check_valid("p0_rd_valid_o", 1'b0, p0_rd_valid_o);
        check_valid("p1_rd_valid_o", 1'b0, p1_rd_valid_o);
    endtask

    // reads requested while reset is held must not produce a result
    task automatic test_reset_clears_valid();
        repeat (RESET_CYCLES - 3) @(posedge clk_i);
        p0_rd_valid_i <= 1'b1;
        p1_rd_valid_i <= 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        rst_n_i       <= 1'b1;
        p0_rd_valid_i <= 1'b0;
        p1_rd_valid_i <= 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W - 1:0] addr, input data_cache_pkg::word_t data,
                              input data_cache_pkg::byte_en_t be);
        @(posedge clk_i);
        p0_wr_valid_i     <= 1'b1;
        p0_wr_addr_i.flat <= addr;
        p0_wr_data_i      <= data;
        p0_byte_en_i      <= be;
        model[addr] = merge_bytes(model[addr], data, be);
        @(posedge clk_i);
        p0_wr_valid_i <= 1'b0;
    endtask

    // one request per port, then exactly one valid pulse a cycle later
    task automatic read_both(input logic [ADDR_W - 1:0] addr0, input logic [ADDR_W - 1:0] addr1);
        @(posedge clk_i);
        p0_rd_valid_i     <= 1'b1;
        p0_rd_addr_i.flat <= addr0;
        p1_rd_valid_i     <= 1'b1;
        p1_rd_addr_i.flat <= addr1;
        @(posedge clk_i);
        p0_rd_valid_i <= 1'b0;
        p1_rd_valid_i <= 1'b0;
        @(negedge clk_i);
        check_valid("p0_rd_valid_o", 1'b1, p0_rd_valid_o);
        check_valid("p1_rd_valid_o", 1'b1, p1_rd_valid_o);
        check_word("p0_rd_data_o", model[addr0], p0_rd_data_o);
        check_word("p1_rd_data_o", model[addr1], p1_rd_data_o);
        check_idle();
    endtask

    task automatic fill_memory();
        for (int a = 0; a < ADDR_COUNT; a++) begin
            @(posedge clk_i);
            p0_wr_valid_i     <= 1'b1;
            p0_wr_addr_i.flat <= a[ADDR_W - 1:0];
            p0_wr_data_i      <= fill_word(a[ADDR_W - 1:0]);
            p0_byte_en_i      <= '1;
            model[a] = fill_word(a[ADDR_W - 1:0]);
        end
        @(posedge clk_i);
        p0_wr_valid_i <= 1'b0;
    endtask

    task automatic test_reset_idle();
        repeat (4) check_idle();
        read_both(10'h001, 10'h3fe);
    endtask

    task automatic test_bank_spread();
        logic [ADDR_W - 1:0] addr;
        for (int b = 0; b < BANK_COUNT; b++) begin
            addr = {b[1:0], 8'h5a};  // same row in every bank
            write_word(addr, $random(seed), 4'hf);
            addr = {b[1:0], 8'h00};
            write_word(addr, $random(seed), 4'hf);
        end
        for (int b = 0; b < BANK_COUNT; b++) begin
            read_both({b[1:0], 8'h5a}, {2'd3 - b[1:0], 8'h5a});
            read_both({b[1:0], 8'h00}, {b[1:0], 8'h00});
        end
    endtask

    task automatic test_byte_enables();
        write_word(10'h011, $random(seed), 4'b0001);
        read_both(10'h011, 10'h011);
        write_word(10'h122, $random(seed), 4'b1010);
        read_both(10'h122, 10'h122);
        write_word(10'h233, $random(seed), 4'b0110);
        read_both(10'h233, 10'h233);
        write_word(10'h344, $random(seed), 4'b0000);  // no byte enabled, word unchanged
        read_both(10'h344, 10'h344);
        write_word(10'h344, $random(seed), 4'b1000);
        write_word(10'h344, $random(seed), 4'b0001);
        read_both(10'h344, 10'h011);
    endtask

    task automatic collide(input logic [ADDR_W - 1:0] addr, input data_cache_pkg::word_t data,
                           input data_cache_pkg::byte_en_t be);
        data_cache_pkg::word_t old_word;
        old_word = model[addr];
        @(posedge clk_i);
        p0_wr_valid_i     <= 1'b1;
        p0_wr_addr_i.flat <= addr;
        p0_wr_data_i      <= data;
        p0_byte_en_i      <= be;
        p0_rd_valid_i     <= 1'b1;
        p0_rd_addr_i.flat <= addr;
        p1_rd_valid_i     <= 1'b1;
        p1_rd_addr_i.flat <= addr;
        model[addr] = merge_bytes(model[addr], data, be);
        @(posedge clk_i);
        p0_wr_valid_i <= 1'b0;
        p0_rd_valid_i <= 1'b0;
        p1_rd_valid_i <= 1'b0;
        @(negedge clk_i);
        check_valid("p0_rd_valid_o", 1'b1, p0_rd_valid_o);
        check_valid("p1_rd_valid_o", 1'b1, p1_rd_valid_o);
        check_word("p0_rd_data_o", old_word, p0_rd_data_o);
        check_word("p1_rd_data_o", old_word, p1_rd_data_o);
        check_idle();
        read_both(addr, addr);
    endtask

    task automatic test_read_stream();
        int r0;
        int r1;
        logic [ADDR_W - 1:0] a0;
        logic [ADDR_W - 1:0] a1;
        for (int c = 0; c <= STREAM_LEN; c++) begin
            @(posedge clk_i);
            if (c < STREAM_LEN) begin
                r0 = $random(seed);
                r1 = $random(seed);
                a0 = r0[ADDR_W - 1:0];
                a1 = r1[ADDR_W - 1:0];
                p0_rd_valid_i     <= 1'b1;
                p0_rd_addr_i.flat <= a0;
                p1_rd_valid_i     <= 1'b1;
                p1_rd_addr_i.flat <= a1;
                exp_p0.push_back(model[a0]);
                exp_p1.push_back(model[a1]);
            end else begin
                p0_rd_valid_i <= 1'b0;
                p1_rd_valid_i <= 1'b0;
            end
            @(negedge clk_i);
            if (c == 0) begin  // first request not sampled yet
                check_valid("p0_rd_valid_o", 1'b0, p0_rd_valid_o);
                check_valid("p1_rd_valid_o", 1'b0, p1_rd_valid_o);
            end else begin
                check_valid("p0_rd_valid_o", 1'b1, p0_rd_valid_o);
                check_valid("p1_rd_valid_o", 1'b1, p1_rd_valid_o);
                check_word("p0_rd_data_o", exp_p0.pop_front(), p0_rd_data_o);
                check_word("p1_rd_data_o", exp_p1.pop_front(), p1_rd_data_o);
            end
        end
        check_idle();
    endtask

    initial begin
        rst_n_i       = 1'b0;
        p0_wr_valid_i = 1'b0;
        p0_wr_addr_i  = '0;
        p0_wr_data_i  = '0;
        p0_byte_en_i  = '0;
        p0_rd_valid_i = 1'b0;
        p0_rd_addr_i  = '0;
        p1_rd_valid_i = 1'b0;
        p1_rd_addr_i  = '0;
        test_reset_clears_valid();
        fill_memory();  // the banks power up undefined
        test_reset_idle();
        test_bank_spread();
        test_byte_enables();
        collide(10'h0a7, $random(seed), 4'hf);
        collide(10'h1a7, $random(seed), 4'b0101);
        collide(10'h2ff, $random(seed), 4'hf);
        collide(10'h300, $random(seed), 4'b1100);
        test_read_stream();
        if (checks_done == 0) begin
            report_failure("no checks were run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("timeout, the tests did not finish in the expected time");
    end

endmodule : data_cache_block_tb

/* files.f */
hdl/data_cache_pkg.sv
hdl/cache_request_decoder.sv
hdl/data_memory_bank.sv
hdl/bank_read_collector.sv
hdl/data_cache_block.sv
verification/data_cache_block_tb.sv
